/* Makefile */
TOP = cluster_periph_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	out=$$(./obj_dir/sim 2>&1); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+include
hdl/cluster_periph_pkg.sv
hdl/eu_plug_merge.sv
hdl/cluster_ctrl_regs.sv
hdl/cluster_timer.sv
hdl/event_unit_core.sv
hdl/cluster_periph_top.sv
tests/cluster_periph_assertions.sv
tests/cluster_periph_tb.sv

/* hdl/cluster_ctrl_regs.sv */
// cluster control registers: end of computation, fetch enable, per-core boot addresses
`timescale 1ns/1ps
`include "cluster_periph_config.svh"

module cluster_ctrl_regs (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          en_sa_boot_i,
  input  cluster_periph_pkg::periph_req_t               bus_req_i,
  output cluster_periph_pkg::periph_rsp_t               bus_rsp_o,
  output logic                                          eoc_o,
  output cluster_periph_pkg::core_vec_t                 fetch_enable_o,
  output cluster_periph_pkg::addr_t [`CP_NB_CORES-1:0]  boot_addr_o
);
  import cluster_periph_pkg::*;

  logic                     eoc_q;
  core_vec_t                fetch_en_q;
  addr_t [`CP_NB_CORES-1:0] boot_addr_q;

  logic      wr_en;
  logic      hit_eoc;
  logic      hit_fetch;
  core_vec_t hit_boot;
  data_t     wmask;
  data_t     rdata;

  logic      r_valid_q;
  per_id_t   r_id_q;
  data_t     r_rdata_q;

  assign wr_en     = bus_req_i.req && !bus_req_i.wen;
  assign wmask     = be_to_mask(bus_req_i.be);
  assign hit_eoc   = bus_req_i.add[7:0] == `CP_OFS_EOC;
  assign hit_fetch = bus_req_i.add[7:0] == `CP_OFS_FETCH_EN;

  // ************************************************
  // decode and read mux
  // ************************************************
  always_comb begin
    rdata = '0;
    if (hit_eoc) rdata[0] = eoc_q;
    if (hit_fetch) rdata[`CP_NB_CORES-1:0] = fetch_en_q;
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      hit_boot[i] = bus_req_i.add[7:0] == 8'(`CP_OFS_BOOT_ADDR + 4*i);
      if (hit_boot[i]) rdata = boot_addr_q[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        boot_addr_q[i] <= en_sa_boot_i ? `CP_ROM_BOOT_ADDR : `CP_BOOT_ADDR;
      end
    end else if (wr_en) begin
      if (hit_eoc && wmask[0]) eoc_q <= bus_req_i.wdata[0];
      if (hit_fetch) begin
        fetch_en_q <= (fetch_en_q & ~wmask[`CP_NB_CORES-1:0]) |
                      (bus_req_i.wdata[`CP_NB_CORES-1:0] & wmask[`CP_NB_CORES-1:0]);
      end
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        if (hit_boot[i]) begin
          boot_addr_q[i] <= (boot_addr_q[i] & ~wmask) | (bus_req_i.wdata & wmask);
        end
      end
    end
  end

  // response one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) r_valid_q <= 1'b0;
    else r_valid_q <= bus_req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      r_id_q    <= bus_req_i.id;
      r_rdata_q <= bus_req_i.wen ? rdata : '0;
    end
  end

  assign bus_rsp_o.gnt     = bus_req_i.req;
  assign bus_rsp_o.r_valid = r_valid_q;
  assign bus_rsp_o.r_rdata = r_rdata_q;
  assign bus_rsp_o.r_id    = r_id_q;

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

/* hdl/cluster_periph_pkg.sv */
// bus and per-core vector types, peripheral request and response structs, byte-enable mask
`include "cluster_periph_config.svh"

package cluster_periph_pkg;

  // bus fields
  typedef logic [31:0]             addr_t;
  typedef logic [31:0]             data_t;
  typedef logic [3:0]              be_t;
  typedef logic [`CP_NB_CORES:0]   per_id_t;

  // per-core quantities
  typedef logic [`CP_NB_CORES-1:0] core_vec_t;
  typedef logic [15:0]             evt_vec_t;
  typedef logic [4:0]              irq_id_t;
  typedef logic [3:0]              acc_evt_t;

  // wen high means read
  typedef struct packed {
    logic    req;
    addr_t   add;
    logic    wen;
    data_t   wdata;
    be_t     be;
    per_id_t id;
  } periph_req_t;

  typedef struct packed {
    logic    gnt;
    logic    r_valid;
    data_t   r_rdata;
    per_id_t r_id;
  } periph_rsp_t;

  // expands byte enables to a bit mask over the data word
  function automatic data_t be_to_mask(be_t be);
    data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

endpackage

/* hdl/cluster_periph_top.sv */
// cluster peripheral top: control registers, timer, event unit plug merge and event unit
`timescale 1ns/1ps
`include "cluster_periph_config.svh"

module cluster_periph_top (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            en_sa_boot_i,

  // peripheral slots
  input  cluster_periph_pkg::periph_req_t                 ctrl_req_i,
  input  cluster_periph_pkg::periph_req_t                 timer_req_i,
  input  cluster_periph_pkg::periph_req_t [1:0]           eu_req_i,
  output cluster_periph_pkg::periph_rsp_t                 ctrl_rsp_o,
  output cluster_periph_pkg::periph_rsp_t                 timer_rsp_o,
  output cluster_periph_pkg::periph_rsp_t [1:0]           eu_rsp_o,

  // external events
  input  logic                                            dma_cl_event_i,
  input  logic                                            dma_cl_irq_i,
  input  cluster_periph_pkg::acc_evt_t [`CP_NB_CORES-1:0] hwpe_events_i,

  // cluster and core control
  output logic                                            eoc_o,
  output cluster_periph_pkg::core_vec_t                   fetch_enable_o,
  output cluster_periph_pkg::addr_t [`CP_NB_CORES-1:0]    boot_addr_o,
  output logic                                            busy_o,
  output cluster_periph_pkg::core_vec_t                   irq_req_o,
  output cluster_periph_pkg::irq_id_t [`CP_NB_CORES-1:0]  irq_id_o
);
  import cluster_periph_pkg::*;

  periph_req_t eu_req;
  periph_rsp_t eu_rsp;
  logic        timer_evt;

  // ************************************************
  // end of computation and boot control
  // ************************************************
  cluster_ctrl_regs i_ctrl_regs (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .bus_req_i      ( ctrl_req_i     ),
    .bus_rsp_o      ( ctrl_rsp_o     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  // ************************************************
  // timer
  // ************************************************
  cluster_timer i_timer (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .bus_req_i   ( timer_req_i ),
    .bus_rsp_o   ( timer_rsp_o ),
    .timer_evt_o ( timer_evt   ),
    .busy_o      ( busy_o      )
  );

  // ************************************************
  // event unit, two plugs merged onto one port
  // ************************************************
  eu_plug_merge i_eu_merge (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .plug_req_i ( eu_req_i ),
    .plug_rsp_o ( eu_rsp_o ),
    .eu_req_o   ( eu_req   ),
    .eu_rsp_i   ( eu_rsp   )
  );

  event_unit_core i_event_unit (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .bus_req_i   ( eu_req         ),
    .bus_rsp_o   ( eu_rsp         ),
    .timer_evt_i ( timer_evt      ),
    .dma_evt_i   ( dma_cl_event_i ),
    .dma_irq_i   ( dma_cl_irq_i   ),
    .acc_evt_i   ( hwpe_events_i  ),
    .irq_req_o   ( irq_req_o      ),
    .irq_id_o    ( irq_id_o       )
  );

endmodule

/* hdl/cluster_timer.sv */
// cluster timer: configuration, counter and compare registers with compare-match event
`timescale 1ns/1ps
`include "cluster_periph_config.svh"

module cluster_timer (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  cluster_periph_pkg::periph_req_t bus_req_i,
  output cluster_periph_pkg::periph_rsp_t bus_rsp_o,
  output logic                            timer_evt_o,
  output logic                            busy_o
);
  import cluster_periph_pkg::*;

  logic    en_q;
  data_t   cnt_q;
  data_t   cmp_q;
  logic    match;

  logic    wr_en;
  logic    hit_cfg;
  logic    hit_cnt;
  logic    hit_cmp;
  data_t   wmask;
  data_t   rdata;

  logic    r_valid_q;
  per_id_t r_id_q;
  data_t   r_rdata_q;

  assign wr_en   = bus_req_i.req && !bus_req_i.wen;
  assign wmask   = be_to_mask(bus_req_i.be);
  assign hit_cfg = bus_req_i.add[7:0] == `CP_OFS_TIMER_CFG;
  assign hit_cnt = bus_req_i.add[7:0] == `CP_OFS_TIMER_CNT;
  assign hit_cmp = bus_req_i.add[7:0] == `CP_OFS_TIMER_CMP;

  // ************************************************
  // counter
  // ************************************************
  assign match = en_q && (cnt_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q  <= 1'b0;
      cnt_q <= '0;
      cmp_q <= '1;
    end else begin
      // wrap on match, otherwise count while enabled
      if (match) cnt_q <= '0;
      else if (en_q) cnt_q <= cnt_q + 32'd1;
      // bus writes override the counting
      if (wr_en && hit_cfg && wmask[0]) begin
        en_q <= bus_req_i.wdata[0];
        if (bus_req_i.wdata[1]) cnt_q <= '0;
      end
      if (wr_en && hit_cnt) cnt_q <= (cnt_q & ~wmask) | (bus_req_i.wdata & wmask);
      if (wr_en && hit_cmp) cmp_q <= (cmp_q & ~wmask) | (bus_req_i.wdata & wmask);
    end
  end

  // count reset bit always reads back as 0
  always_comb begin
    rdata = '0;
    if (hit_cfg) rdata[0] = en_q;
    if (hit_cnt) rdata = cnt_q;
    if (hit_cmp) rdata = cmp_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) r_valid_q <= 1'b0;
    else r_valid_q <= bus_req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      r_id_q    <= bus_req_i.id;
      r_rdata_q <= bus_req_i.wen ? rdata : '0;
    end
  end

  assign bus_rsp_o.gnt     = bus_req_i.req;
  assign bus_rsp_o.r_valid = r_valid_q;
  assign bus_rsp_o.r_rdata = r_rdata_q;
  assign bus_rsp_o.r_id    = r_id_q;

  assign timer_evt_o = match;
  assign busy_o      = en_q;

endmodule

/* hdl/eu_plug_merge.sv */
// event unit plug merge: fixed-priority select of two bus plugs and response routing
`timescale 1ns/1ps

module eu_plug_merge (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  cluster_periph_pkg::periph_req_t [1:0] plug_req_i,
  output cluster_periph_pkg::periph_rsp_t [1:0] plug_rsp_o,
  output cluster_periph_pkg::periph_req_t       eu_req_o,
  input  cluster_periph_pkg::periph_rsp_t       eu_rsp_i
);
  import cluster_periph_pkg::*;

  // 1 selects plug 1, only when plug 0 is idle
  logic       sel;
  logic       sel_q;
  logic [1:0] gnt_oh;
  logic [1:0] rsp_oh;

  assign sel      = !plug_req_i[0].req && plug_req_i[1].req;
  assign eu_req_o = plug_req_i[sel];

  // remember who was granted so the response goes back to that plug only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= 1'b0;
    end else if (eu_req_o.req && eu_rsp_i.gnt) begin
      sel_q <= sel;
    end
  end

  assign gnt_oh = {sel, !sel} & {2{eu_rsp_i.gnt}};
  assign rsp_oh = {sel_q, !sel_q} & {2{eu_rsp_i.r_valid}};

  // ************************************************
  // per-plug response
  // ************************************************
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      plug_rsp_o[p].gnt     = gnt_oh[p];
      plug_rsp_o[p].r_valid = rsp_oh[p];
      plug_rsp_o[p].r_rdata = rsp_oh[p] ? eu_rsp_i.r_rdata : '0;
      plug_rsp_o[p].r_id    = rsp_oh[p] ? eu_rsp_i.r_id : '0;
    end
  end

endmodule

/* hdl/event_unit_core.sv */
// event unit: per-core event buffers and masks, software trigger, irq request and id
`timescale 1ns/1ps
`include "cluster_periph_config.svh"

module event_unit_core (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  cluster_periph_pkg::periph_req_t                 bus_req_i,
  output cluster_periph_pkg::periph_rsp_t                 bus_rsp_o,
  input  logic                                            timer_evt_i,
  input  logic                                            dma_evt_i,
  input  logic                                            dma_irq_i,
  input  cluster_periph_pkg::acc_evt_t [`CP_NB_CORES-1:0] acc_evt_i,
  output cluster_periph_pkg::core_vec_t                   irq_req_o,
  output cluster_periph_pkg::irq_id_t [`CP_NB_CORES-1:0]  irq_id_o
);
  import cluster_periph_pkg::*;

  evt_vec_t [`CP_NB_CORES-1:0] mask_q;
  evt_vec_t [`CP_NB_CORES-1:0] buf_q;
  evt_vec_t [`CP_NB_CORES-1:0] evt_set;
  evt_vec_t [`CP_NB_CORES-1:0] buf_clr;
  evt_vec_t [`CP_NB_CORES-1:0] pending;

  logic      wr_en;
  logic      hit_sw;
  core_vec_t hit_mask;
  core_vec_t hit_buf;
  logic [7:0] sw_trig;
  data_t     wmask;
  data_t     rdata;

  logic      r_valid_q;
  per_id_t   r_id_q;
  data_t     r_rdata_q;

  assign wr_en   = bus_req_i.req && !bus_req_i.wen;
  assign wmask   = be_to_mask(bus_req_i.be);
  assign hit_sw  = bus_req_i.add[7:0] == `CP_OFS_EVT_SW_TRIG;
  assign sw_trig = (wr_en && hit_sw) ? (bus_req_i.wdata[7:0] & wmask[7:0]) : '0;

  // ************************************************
  // decode, event sources and read mux
  // ************************************************
  always_comb begin
    rdata = '0;
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      hit_mask[i] = bus_req_i.add[7:0] == 8'(`CP_OFS_EVT_MASK + 4*i);
      hit_buf[i]  = bus_req_i.add[7:0] == 8'(`CP_OFS_EVT_BUFFER + 4*i);
      if (hit_mask[i]) rdata[15:0] = mask_q[i];
      if (hit_buf[i]) rdata[15:0] = buf_q[i];
      // a write to the buffer clears the bits written as 1
      buf_clr[i] = (wr_en && hit_buf[i]) ? (bus_req_i.wdata[15:0] & wmask[15:0]) : '0;
      // shared sources reach every core, accelerator events only their own
      evt_set[i]                          = '0;
      evt_set[i][`CP_EVT_TIMER]           = timer_evt_i;
      evt_set[i][`CP_EVT_DMA]             = dma_evt_i;
      evt_set[i][`CP_EVT_DMA_IRQ]         = dma_irq_i;
      evt_set[i][`CP_EVT_ACC_BASE +: 4]   = acc_evt_i[i];
      evt_set[i][`CP_EVT_SW_BASE +: 8]    = sw_trig;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q <= '0;
      buf_q  <= '0;
    end else begin
      for (int i = 0; i < `CP_NB_CORES; i++) begin
        if (wr_en && hit_mask[i]) begin
          mask_q[i] <= (mask_q[i] & ~wmask[15:0]) | (bus_req_i.wdata[15:0] & wmask[15:0]);
        end
        // set wins over clear
        buf_q[i] <= (buf_q[i] & ~buf_clr[i]) | evt_set[i];
      end
    end
  end

  // lowest pending bit gives the irq id
  always_comb begin
    for (int i = 0; i < `CP_NB_CORES; i++) begin
      pending[i]   = buf_q[i] & mask_q[i];
      irq_req_o[i] = |pending[i];
      irq_id_o[i]  = '0;
      for (int k = $bits(evt_vec_t) - 1; k >= 0; k--) begin
        if (pending[i][k]) irq_id_o[i] = irq_id_t'(k);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) r_valid_q <= 1'b0;
    else r_valid_q <= bus_req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      r_id_q    <= bus_req_i.id;
      r_rdata_q <= bus_req_i.wen ? rdata : '0;
    end
  end

  assign bus_rsp_o.gnt     = bus_req_i.req;
  assign bus_rsp_o.r_valid = r_valid_q;
  assign bus_rsp_o.r_rdata = r_rdata_q;
  assign bus_rsp_o.r_id    = r_id_q;

endmodule

/* include/cluster_periph_config.svh */
// core count, reset boot addresses, slot register offsets and event bit positions
`ifndef CLUSTER_PERIPH_CONFIG_SVH
`define CLUSTER_PERIPH_CONFIG_SVH

`define CP_NB_CORES        8

// reset boot addresses, selected by en_sa_boot_i
`define CP_ROM_BOOT_ADDR   32'h1A00_0000
`define CP_BOOT_ADDR       32'h1C00_0000

// control register slot
`define CP_OFS_EOC         8'h00
`define CP_OFS_FETCH_EN    8'h08
`define CP_OFS_BOOT_ADDR   8'h40

// timer slot
`define CP_OFS_TIMER_CFG   8'h00
`define CP_OFS_TIMER_CNT   8'h04
`define CP_OFS_TIMER_CMP   8'h08

// event unit slot, mask and buffer have one word per core
`define CP_OFS_EVT_MASK    8'h00
`define CP_OFS_EVT_BUFFER  8'h20
`define CP_OFS_EVT_SW_TRIG 8'h60

// event buffer bit map
`define CP_EVT_TIMER       0
`define CP_EVT_DMA         1
`define CP_EVT_DMA_IRQ     2
`define CP_EVT_ACC_BASE    4
`define CP_EVT_SW_BASE     8

`endif

/* tests/cluster_periph_assertions.sv */
// bus response timing, plug merge grant exclusivity and irq state after reset, bound to the top
`timescale 1ns/1ps

module cluster_periph_assertions (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input cluster_periph_pkg::periph_req_t       ctrl_req_i,
  input cluster_periph_pkg::periph_req_t       timer_req_i,
  input cluster_periph_pkg::periph_rsp_t       ctrl_rsp_o,
  input cluster_periph_pkg::periph_rsp_t       timer_rsp_o,
  input cluster_periph_pkg::periph_rsp_t [1:0] eu_rsp_o,
  input cluster_periph_pkg::core_vec_t         irq_req_o
);
  import cluster_periph_pkg::*;

  // a grant is answered in the next cycle
  ctrl_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_req_i.req && ctrl_rsp_o.gnt |=> ctrl_rsp_o.r_valid)
    else $error("ctrl slot: no r_valid one cycle after the grant");

  timer_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    timer_req_i.req && timer_rsp_o.gnt |=> timer_rsp_o.r_valid)
    else $error("timer slot: no r_valid one cycle after the grant");

  eu0_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eu_rsp_o[0].gnt |=> eu_rsp_o[0].r_valid)
    else $error("event unit plug 0: no r_valid one cycle after the grant");

  eu1_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eu_rsp_o[1].gnt |=> eu_rsp_o[1].r_valid)
    else $error("event unit plug 1: no r_valid one cycle after the grant");

  plug_excl_a: assert property (@(posedge clk_i) !(eu_rsp_o[0].gnt && eu_rsp_o[1].gnt))
    else $error("both event unit plugs granted in the same cycle");

  irq_reset_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> irq_req_o == '0)
    else $error("irq_req_o not low when reset is released");

endmodule

bind cluster_periph_top cluster_periph_assertions u_assertions (.*);

/* tests/cluster_periph_tb.sv */
// testbench: clock, reset, bus tasks, reference model, compare tasks, response monitor, watchdog
`timescale 1ns/1ps
`include "cluster_periph_config.svh"

module cluster_periph_tb;
  import cluster_periph_pkg::*;

  localparam int NB          = `CP_NB_CORES;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 2000;
  localparam int SLOT_CTRL   = 0;
  localparam int SLOT_TIMER  = 1;
  localparam int SLOT_EU0    = 2;
  localparam int SLOT_EU1    = 3;

  // what the monitor expects for one granted access
  typedef struct packed {
    logic    chk;
    per_id_t id;
    data_t   data;
  } exp_t;

  logic                clk;
  logic                rst_n;
  logic                en_sa_boot;
  periph_req_t         ctrl_req;
  periph_req_t         timer_req;
  periph_req_t [1:0]   eu_req;
  periph_rsp_t         ctrl_rsp;
  periph_rsp_t         timer_rsp;
  periph_rsp_t [1:0]   eu_rsp;
  logic                dma_evt;
  logic                dma_irq;
  acc_evt_t [NB-1:0]   hwpe_evt;
  logic                eoc;
  core_vec_t           fetch_en;
  addr_t [NB-1:0]      boot_addr;
  logic                busy;
  core_vec_t           irq_req;
  irq_id_t [NB-1:0]    irq_id;

  // shadow state of the reference model
  logic      sh_eoc;
  core_vec_t sh_fetch;
  addr_t     sh_boot [NB];
  logic      sh_en;
  data_t     sh_cmp;
  evt_vec_t  sh_mask [NB];
  evt_vec_t  sh_buf [NB];

  exp_t  exp_q [4][$];
  string test_name = "init";

  cluster_periph_top DUT (
    .clk_i          ( clk        ),
    .rst_n_i        ( rst_n      ),
    .en_sa_boot_i   ( en_sa_boot ),
    .ctrl_req_i     ( ctrl_req   ),
    .timer_req_i    ( timer_req  ),
    .eu_req_i       ( eu_req     ),
    .ctrl_rsp_o     ( ctrl_rsp   ),
    .timer_rsp_o    ( timer_rsp  ),
    .eu_rsp_o       ( eu_rsp     ),
    .dma_cl_event_i ( dma_evt    ),
    .dma_cl_irq_i   ( dma_irq    ),
    .hwpe_events_i  ( hwpe_evt   ),
    .eoc_o          ( eoc        ),
    .fetch_enable_o ( fetch_en   ),
    .boot_addr_o    ( boot_addr  ),
    .busy_o         ( busy       ),
    .irq_req_o      ( irq_req    ),
    .irq_id_o       ( irq_id     )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (N_TESTS * TEST_CYCLES) @(posedge clk);
    $display("watchdog expired, the run hung in test %s", test_name);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  // **************************************************
  // compare tasks
  // **************************************************
  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_core_vec(input string what, input core_vec_t exp, input core_vec_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_irq_id(input string what, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_id(input string what, input per_id_t exp, input per_id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // **************************************************
  // reference model
  // **************************************************
  function automatic data_t lane_mask(be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic addr_t word_addr(logic [7:0] ofs, int word);
    return addr_t'(ofs) + addr_t'(4 * word);
  endfunction

  function automatic void model_reset(logic sa);
    sh_eoc   = 1'b0;
    sh_fetch = '0;
    sh_en    = 1'b0;
    sh_cmp   = '1;
    for (int i = 0; i < NB; i++) begin
      sh_boot[i] = sa ? `CP_ROM_BOOT_ADDR : `CP_BOOT_ADDR;
      sh_mask[i] = '0;
      sh_buf[i]  = '0;
    end
  endfunction

  // applies one granted access to the shadow and returns the expected r_rdata
  function automatic data_t ref_model(int slot, addr_t add, logic wen, data_t wdata, be_t be);
    data_t      m;
    data_t      rd;
    logic [7:0] ofs;
    m   = lane_mask(be);
    rd  = '0;
    ofs = add[7:0];
    if (slot == SLOT_CTRL) begin
      if (ofs == `CP_OFS_EOC) begin
        rd = {31'b0, sh_eoc};
        if (!wen && be[0]) sh_eoc = wdata[0];
      end else if (ofs == `CP_OFS_FETCH_EN) begin
        rd = {24'b0, sh_fetch};
        if (!wen) sh_fetch = (sh_fetch & ~m[NB-1:0]) | (wdata[NB-1:0] & m[NB-1:0]);
      end
      for (int i = 0; i < NB; i++) begin
        if (ofs == 8'(`CP_OFS_BOOT_ADDR + 4 * i)) begin
          rd = sh_boot[i];
          if (!wen) sh_boot[i] = (sh_boot[i] & ~m) | (wdata & m);
        end
      end
    end else if (slot == SLOT_TIMER) begin
      if (ofs == `CP_OFS_TIMER_CFG) begin
        rd = {31'b0, sh_en};
        if (!wen && be[0]) sh_en = wdata[0];
      end else if (ofs == `CP_OFS_TIMER_CMP) begin
        rd = sh_cmp;
        if (!wen) sh_cmp = (sh_cmp & ~m) | (wdata & m);
      end
    end else begin
      for (int i = 0; i < NB; i++) begin
        if (!wen && ofs == `CP_OFS_EVT_SW_TRIG) begin
          sh_buf[i][`CP_EVT_SW_BASE +: 8] = sh_buf[i][`CP_EVT_SW_BASE +: 8] | (wdata[7:0] & m[7:0]);
        end
        if (ofs == 8'(`CP_OFS_EVT_MASK + 4 * i)) begin
          rd = {16'b0, sh_mask[i]};
          if (!wen) sh_mask[i] = (sh_mask[i] & ~m[15:0]) | (wdata[15:0] & m[15:0]);
        end
        if (ofs == 8'(`CP_OFS_EVT_BUFFER + 4 * i)) begin
          rd = {16'b0, sh_buf[i]};
          if (!wen) sh_buf[i] = sh_buf[i] & ~(wdata[15:0] & m[15:0]);
        end
      end
    end
    return wen ? rd : '0;
  endfunction

  function automatic irq_id_t lowest_pending(int core);
    evt_vec_t p;
    p = sh_buf[core] & sh_mask[core];
    for (int k = 0; k < 16; k++) begin
      if (p[k]) return irq_id_t'(k);
    end
    return '0;
  endfunction

  task automatic check_irq_outputs();
    core_vec_t exp_req;
    for (int i = 0; i < NB; i++) begin
      exp_req[i] = |(sh_buf[i] & sh_mask[i]);
    end
    check_core_vec("irq_req_o", exp_req, irq_req);
    for (int i = 0; i < NB; i++) begin
      check_irq_id($sformatf("irq_id_o[%0d]", i), lowest_pending(i), irq_id[i]);
    end
  endtask

  // **************************************************
  // bus driver
  // **************************************************
  task automatic drive_slot(input int slot, input periph_req_t r);
    case (slot)
      SLOT_CTRL:  ctrl_req <= r;
      SLOT_TIMER: timer_req <= r;
      SLOT_EU0:   eu_req[0] <= r;
      default:    eu_req[1] <= r;
    endcase
  endtask

  function automatic periph_rsp_t rsp_of(int slot);
    case (slot)
      SLOT_CTRL:  return ctrl_rsp;
      SLOT_TIMER: return timer_rsp;
      SLOT_EU0:   return eu_rsp[0];
      default:    return eu_rsp[1];
    endcase
  endfunction

  // starts on a rising edge, holds req until gnt, returns at r_valid
  task automatic bus_access(input int slot, input addr_t add, input logic wen,
                            input data_t wdata, input be_t be, input logic chk,
                            output data_t rdata);
    periph_req_t r;
    periph_rsp_t rsp;
    exp_t        e;
    r.req   = 1'b1;
    r.add   = add;
    r.wen   = wen;
    r.wdata = wdata;
    r.be    = be;
    r.id    = per_id_t'(slot + 1);
    drive_slot(slot, r);
    do begin
      @(posedge clk);
      rsp = rsp_of(slot);
    end while (!rsp.gnt);
    // the model sees accesses in grant order
    e.chk  = chk;
    e.id   = r.id;
    e.data = ref_model(slot, add, wen, wdata, be);
    exp_q[slot].push_back(e);
    r.req = 1'b0;
    drive_slot(slot, r);
    do begin
      @(posedge clk);
      rsp = rsp_of(slot);
    end while (!rsp.r_valid);
    rdata = rsp.r_rdata;
  endtask

  task automatic bus_write(input int slot, input addr_t add, input data_t wdata, input be_t be);
    data_t rd;
    bus_access(slot, add, 1'b0, wdata, be, 1'b1, rd);
  endtask

  task automatic bus_read(input int slot, input addr_t add, output data_t rdata);
    bus_access(slot, add, 1'b1, '0, '0, 1'b1, rdata);
  endtask

  task automatic apply_reset(input logic sa);
    en_sa_boot <= sa;
    rst_n      <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    model_reset(sa);
  endtask

  // every response must match the oldest access granted on its own slot
  always @(posedge clk) begin
    periph_rsp_t rsp;
    exp_t        e;
    for (int s = 0; s < 4; s++) begin
      rsp = rsp_of(s);
      if (rst_n && rsp.r_valid) begin
        if (exp_q[s].size() == 0) begin
          $display("slot %0d returned a response that no granted access was waiting for", s);
          abort_run();
        end
        e = exp_q[s].pop_front();
        check_id($sformatf("slot %0d r_id", s), e.id, rsp.r_id);
        if (e.chk) check_data($sformatf("slot %0d r_rdata", s), e.data, rsp.r_rdata);
      end
    end
  end

  // **************************************************
  // tests
  // **************************************************
  initial begin
    data_t      rd;
    data_t      d;
    addr_t      a;
    int         c;
    int         k;
    int         s;
    time        t0;
    time        t1;
    acc_evt_t   ev;
    logic [7:0] sw;

    void'($urandom(60));
    rst_n      = 1'b0;
    en_sa_boot = 1'b0;
    ctrl_req   = '0;
    timer_req  = '0;
    eu_req     = '0;
    dma_evt    = 1'b0;
    dma_irq    = 1'b0;
    hwpe_evt   = '0;
    @(posedge clk);

    // standalone boot first, normal boot second
    test_name = "reset_boot";
    for (int run = 0; run < 2; run++) begin
      apply_reset(run == 0);
      for (int i = 0; i < NB; i++) begin
        bus_read(SLOT_CTRL, word_addr(`CP_OFS_BOOT_ADDR, i), rd);
        check_data($sformatf("boot_addr_o[%0d]", i), sh_boot[i], boot_addr[i]);
      end
      check_data("eoc_o", '0, data_t'(eoc));
      check_core_vec("fetch_enable_o", '0, fetch_en);
      check_data("busy_o", data_t'(sh_en), data_t'(busy));
    end

    test_name = "ctrl_regs";
    for (int n = 0; n < 40; n++) begin
      a = addr_t'($urandom_range(0, 31) * 4);
      if (n % 8 == 0) a = word_addr(`CP_OFS_EOC, 0);
      if (n % 8 == 4) a = word_addr(`CP_OFS_FETCH_EN, 0);
      bus_write(SLOT_CTRL, a, $urandom(), be_t'($urandom_range(0, 15)));
      bus_read(SLOT_CTRL, a, rd);
    end
    check_data("eoc_o", data_t'(sh_eoc), data_t'(eoc));
    check_core_vec("fetch_enable_o", sh_fetch, fetch_en);
    for (int i = 0; i < NB; i++) begin
      check_data($sformatf("boot_addr_o[%0d]", i), sh_boot[i], boot_addr[i]);
    end

    test_name = "timer";
    c = $urandom_range(10, 60);
    bus_write(SLOT_TIMER, word_addr(`CP_OFS_TIMER_CMP, 0), data_t'(c), 4'hF);
    bus_write(SLOT_TIMER, word_addr(`CP_OFS_TIMER_CFG, 0), 32'h2, 4'hF);
    bus_write(SLOT_EU0, word_addr(`CP_OFS_EVT_MASK, 0), 32'h1 << `CP_EVT_TIMER, 4'hF);
    bus_write(SLOT_TIMER, word_addr(`CP_OFS_TIMER_CFG, 0), 32'h1, 4'hF);
    repeat (c + 8) @(posedge clk);
    check_data("busy_o", data_t'(sh_en), data_t'(busy));
    // a compare match reaches every core
    for (int i = 0; i < NB; i++) begin
      sh_buf[i][`CP_EVT_TIMER] = 1'b1;
    end
    bus_read(SLOT_EU0, word_addr(`CP_OFS_EVT_BUFFER, 0), rd);
    check_irq_outputs();
    bus_access(SLOT_TIMER, word_addr(`CP_OFS_TIMER_CNT, 0), 1'b1, '0, '0, 1'b0, rd);
    if (rd > data_t'(c)) begin
      $display("[ERROR] %s: count expected at most %h actual %h", test_name, c, rd);
      abort_run();
    end
    bus_write(SLOT_TIMER, word_addr(`CP_OFS_TIMER_CFG, 0), 32'h0, 4'hF);
    check_data("busy_o", data_t'(sh_en), data_t'(busy));

    test_name = "events";
    for (int i = 0; i < NB; i++) begin
      bus_write(SLOT_EU1, word_addr(`CP_OFS_EVT_BUFFER, i), 32'hFFFF, 4'hF);
    end
    k  = $urandom_range(0, NB - 1);
    ev = acc_evt_t'($urandom_range(1, 15));
    dma_evt     <= 1'b1;
    dma_irq     <= 1'b1;
    hwpe_evt[k] <= ev;
    @(posedge clk);
    dma_evt  <= 1'b0;
    dma_irq  <= 1'b0;
    hwpe_evt <= '0;
    for (int i = 0; i < NB; i++) begin
      sh_buf[i][`CP_EVT_DMA]     = 1'b1;
      sh_buf[i][`CP_EVT_DMA_IRQ] = 1'b1;
    end
    sh_buf[k][`CP_EVT_ACC_BASE +: 4] = sh_buf[k][`CP_EVT_ACC_BASE +: 4] | ev;
    for (int i = 0; i < NB; i++) begin
      d = data_t'($urandom_range(0, 65535));
      bus_write(SLOT_EU0, word_addr(`CP_OFS_EVT_MASK, i), d, 4'hF);
    end
    sw = 8'($urandom_range(1, 255));
    bus_write(SLOT_EU1, word_addr(`CP_OFS_EVT_SW_TRIG, 0), {24'b0, sw}, 4'hF);
    check_irq_outputs();
    for (int i = 0; i < NB; i++) begin
      bus_read(SLOT_EU0, word_addr(`CP_OFS_EVT_BUFFER, i), rd);
    end
    for (int i = 0; i < NB; i++) begin
      bus_write(SLOT_EU1, word_addr(`CP_OFS_EVT_BUFFER, i), 32'hFFFF, 4'hF);
    end
    check_irq_outputs();
    check_core_vec("irq_req_o after clear", '0, irq_req);

    // plug 1 reads the mask that plug 0 writes in the same cycle
    test_name = "plug_merge";
    fork
      begin
        bus_write(SLOT_EU0, word_addr(`CP_OFS_EVT_MASK, 2), 32'h0000_A5A5, 4'hF);
        t0 = $time;
      end
      begin
        bus_read(SLOT_EU1, word_addr(`CP_OFS_EVT_MASK, 2), rd);
        t1 = $time;
      end
    join
    if (t1 <= t0) begin
      $display("plug 1 completed no later than plug 0 although both requested together");
      abort_run();
    end

    test_name = "random_mix";
    for (int n = 0; n < 80; n++) begin
      s = $urandom_range(0, 3);
      a = addr_t'($urandom_range(0, 31) * 4);
      d = $urandom();
      if (s == SLOT_TIMER) begin
        // timer stays stopped so the event buffers hold still
        a    = word_addr($urandom_range(0, 1) == 0 ? `CP_OFS_TIMER_CFG : `CP_OFS_TIMER_CMP, 0);
        d[0] = 1'b0;
      end
      if ($urandom_range(0, 1) == 0) bus_write(s, a, d, be_t'($urandom_range(0, 15)));
      else bus_read(s, a, rd);
    end
    check_irq_outputs();
    check_data("busy_o", data_t'(sh_en), data_t'(busy));

    repeat (2) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule
